// File: sources.f
+incdir+.
soc_bus_pkg.sv
soc_periph_pkg.sv
soc_bus_arbiter.sv
soc_ram.sv
soc_gpio.sv
soc_timer.sv
soc_top.sv
soc_bus_asserts.sv
tb_clk_gen.sv
tb_soc_top.sv

// File: Bender.yml
package:
  name: soc_fabric

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - soc_bus_pkg.sv
      - soc_periph_pkg.sv
      - soc_bus_arbiter.sv
      - soc_ram.sv
      - soc_gpio.sv
      - soc_timer.sv
      - soc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - soc_bus_asserts.sv
      - tb_clk_gen.sv
      - tb_soc_top.sv

// File: tb_soc_top.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module tb_soc_top;
  import soc_bus_pkg::*;

  localparam int ram_slots   = 16;
  localparam int gpio_out_a  = `SOC_GPIO_START;
  localparam int gpio_in_a   = `SOC_GPIO_START + 4;
  localparam int timer_a     = `SOC_TIMER_START;
  localparam int unmapped_a  = 32'h4000_0000;

  // Rough cycle budget of each test at two cycles per bus access
  localparam int test_cycles = 12 + 88 + 24 + 8 + 6 + 90;
  localparam int timeout_cycles = 3 * test_cycles;

  logic                     clk_sys;
  logic                     rst_sys_n;
  logic                     host_req    [`SOC_NR_HOSTS];
  soc_addr_u                host_addr   [`SOC_NR_HOSTS];
  logic                     host_we     [`SOC_NR_HOSTS];
  logic [`SOC_DATA_W/8-1:0] host_be     [`SOC_NR_HOSTS];
  logic [`SOC_DATA_W-1:0]   host_wdata  [`SOC_NR_HOSTS];
  logic                     host_gnt    [`SOC_NR_HOSTS];
  logic                     host_rvalid [`SOC_NR_HOSTS];
  logic [`SOC_DATA_W-1:0]   host_rdata  [`SOC_NR_HOSTS];
  logic                     host_err    [`SOC_NR_HOSTS];
  logic [`SOC_GPI_W-1:0]    gp_i;
  logic [`SOC_GPO_W-1:0]    gp_o;
  logic                     timer_irq;

  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          bus_fails;
  int          last_gnt_cyc [`SOC_NR_HOSTS];
  integer      seed;
  logic [31:0] ram_model [ram_slots];  // Expected RAM contents per slot

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_sys),
    .rst_no (rst_sys_n)
  );

  soc_top i_soc_top (
    .clk_sys_i     (clk_sys),
    .rst_sys_ni    (rst_sys_n),
    .host_req_i    (host_req),
    .host_addr_i   (host_addr),
    .host_we_i     (host_we),
    .host_be_i     (host_be),
    .host_wdata_i  (host_wdata),
    .host_gnt_o    (host_gnt),
    .host_rvalid_o (host_rvalid),
    .host_rdata_o  (host_rdata),
    .host_err_o    (host_err),
    .gp_i          (gp_i),
    .gp_o          (gp_o),
    .timer_irq_o   (timer_irq)
  );

  always @(posedge clk_sys) begin
    cyc <= cyc + 1;
    if (cyc == timeout_cycles) begin
      $display("Run stopped after %0d cycles without reaching the end", cyc);
      $display("Verification failed");
      $finish;
    end
  end

  function automatic logic [31:0] ram_slot_addr(int slot);
    return `SOC_RAM_START + slot * 32'h40;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  // One full transfer that holds req until gnt and then waits for rvalid
  task automatic bus_access(input int h, input logic [31:0] addr, input logic we,
                            input logic [3:0] be, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
    int lat;
    @(posedge clk_sys);
    host_req[h]   <= 1'b1;
    host_addr[h]  <= addr;
    host_we[h]    <= we;
    host_be[h]    <= be;
    host_wdata[h] <= wdata;
    do @(negedge clk_sys); while (!host_gnt[h]);
    last_gnt_cyc[h] = cyc;
    @(posedge clk_sys);
    host_req[h] <= 1'b0;
    lat = 0;
    do begin
      @(negedge clk_sys);
      lat++;
    end while (!host_rvalid[h]);
    checks++;
    assert (lat == 1) else begin
      errors++;
      $display("Host %0d response came %0d cycles after grant instead of one", h, lat);
    end
    rdata = host_rdata[h];
    err   = host_err[h];
  endtask

  task automatic bus_write(input int h, input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] data);
    logic [31:0] rd;
    logic        err;
    bus_access(h, addr, 1'b1, be, data, rd, err);
    check_value("host_err_o", 32'(err), 32'h0);
  endtask

  task automatic bus_read(input int h, input logic [31:0] addr, output logic [31:0] data);
    logic err;
    bus_access(h, addr, 1'b0, 4'h0, 32'h0, data, err);
    check_value("host_err_o", 32'(err), 32'h0);
  endtask

  task automatic ram_write_read();
    logic [31:0] data;
    logic [31:0] rd;
    logic [3:0]  be;
    for (int i = 0; i < ram_slots; i++) begin
      data = $random(seed);
      bus_write(core_data, ram_slot_addr(i), 4'hf, data);
      ram_model[i] = data;
    end
    for (int i = 0; i < ram_slots; i += 2) begin  // Partial writes merge bytes
      data = $random(seed);
      be   = $random(seed);
      bus_write(core_data, ram_slot_addr(i), be, data);
      for (int b = 0; b < 4; b++) begin
        if (be[b]) begin
          ram_model[i][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    for (int i = 0; i < ram_slots; i++) begin
      bus_read(core_data, ram_slot_addr(i), rd);
      check_value("host_rdata_o", rd, ram_model[i]);
    end
  endtask

  task automatic gpio_out_in();
    logic [31:0] data;
    logic [31:0] rd;
    logic [15:0] exp_out;
    logic [7:0]  pins;
    data = $random(seed);
    bus_write(dbg_host, gpio_out_a, 4'b0011, data);
    exp_out = data[15:0];
    check_value("gp_o", 32'(gp_o), 32'(exp_out));
    data = $random(seed);
    bus_write(dbg_host, gpio_out_a, 4'b0010, data);  // Upper byte only
    exp_out[15:8] = data[15:8];
    check_value("gp_o", 32'(gp_o), 32'(exp_out));
    bus_read(dbg_host, gpio_out_a, rd);
    check_value("host_rdata_o", rd, 32'(exp_out));
    pins = $random(seed);
    @(posedge clk_sys);
    gp_i <= pins;
    repeat (4) @(posedge clk_sys);  // Through the synchronizer
    bus_read(dbg_host, gpio_in_a, rd);
    check_value("host_rdata_o", rd, 32'(pins));
    bus_write(dbg_host, gpio_in_a, 4'hf, ~data);
    check_value("gp_o", 32'(gp_o), 32'(exp_out));
  endtask

  task automatic dual_host_contention();
    logic [31:0] rd_core;
    logic [31:0] rd_dbg;
    fork
      bus_read(core_data, ram_slot_addr(3), rd_core);
      bus_read(dbg_host, ram_slot_addr(6), rd_dbg);
    join
    check_value("host_rdata_o", rd_core, ram_model[3]);
    check_value("host_rdata_o", rd_dbg, ram_model[6]);
    checks++;
    assert (last_gnt_cyc[core_data] < last_gnt_cyc[dbg_host]) else begin
      errors++;
      $display("dbg_host was granted before core_data in a tie");
    end
  endtask

  task automatic unmapped_error();
    logic [31:0] rd;
    logic        err;
    bus_access(core_data, unmapped_a, 1'b0, 4'h0, 32'h0, rd, err);
    check_value("host_err_o", 32'(err), 32'h1);
    check_value("host_rdata_o", rd, 32'h0);
    bus_read(core_data, ram_slot_addr(1), rd);
    check_value("host_rdata_o", rd, ram_model[1]);
  endtask

  task automatic timer_interrupt();
    logic [31:0] lo;
    logic [31:0] hi;
    logic [31:0] rd;
    logic [63:0] cmp;
    int          t0;
    int          n;
    bus_read(core_data, timer_a, lo);
    t0 = last_gnt_cyc[core_data];
    bus_read(core_data, timer_a + 4, hi);
    cmp = {hi, lo} + 64'd50;
    bus_write(core_data, timer_a + 8, 4'hf, cmp[31:0]);  // Low half first while hi is all ones
    bus_write(core_data, timer_a + 12, 4'hf, cmp[63:32]);
    bus_read(core_data, timer_a + 8, rd);
    check_value("host_rdata_o", rd, cmp[31:0]);
    while (!timer_irq && (cyc - t0) < 80) @(negedge clk_sys);
    checks++;
    assert (timer_irq && (cyc - t0) >= 40 && (cyc - t0) <= 60) else begin
      errors++;
      $display("Timer interrupt not seen between 40 and 60 cycles, waited %0d", cyc - t0);
    end
    bus_write(core_data, timer_a + 12, 4'hf, 32'hffff_ffff);
    n = 0;
    while (timer_irq && n < 4) begin
      @(negedge clk_sys);
      n++;
    end
    check_value("timer_irq_o", 32'(timer_irq), 32'h0);
  endtask

  initial begin
    for (int h = 0; h < `SOC_NR_HOSTS; h++) begin
      host_req[h]     = 1'b0;
      host_addr[h]    = '0;
      host_we[h]      = 1'b0;
      host_be[h]      = '0;
      host_wdata[h]   = '0;
      last_gnt_cyc[h] = 0;
    end
    gp_i = '0;
    seed = 32'h2cb1_f299;
    @(posedge rst_sys_n);
    @(negedge clk_sys);
    for (int h = 0; h < `SOC_NR_HOSTS; h++) begin
      check_value("host_gnt_o", 32'(host_gnt[h]), 32'h0);
      check_value("host_rvalid_o", 32'(host_rvalid[h]), 32'h0);
      check_value("host_err_o", 32'(host_err[h]), 32'h0);
    end
    check_value("gp_o", 32'(gp_o), 32'h0);
    check_value("timer_irq_o", 32'(timer_irq), 32'h0);
    ram_write_read();
    gpio_out_in();
    dual_host_contention();
    unmapped_error();
    timer_interrupt();
    bus_fails = i_soc_top.i_arbiter.i_bus_asserts.fail_cnt;
    $display("Checks run: %0d, errors: %0d, bus assertion failures: %0d",
             checks, errors, bus_fails);
    if (errors == 0 && bus_fails == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;  // 20 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (10) @(posedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

// File: soc_bus_asserts.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_bus_asserts (
  input logic clk_sys_i,
  input logic rst_sys_ni,
  input logic host_gnt_i    [`SOC_NR_HOSTS],
  input logic host_rvalid_i [`SOC_NR_HOSTS],
  input logic host_err_i    [`SOC_NR_HOSTS]
);

  logic [`SOC_NR_HOSTS-1:0] gnt_vec;
  int unsigned              fail_cnt = 0;  // Failed assertions so far

  always_comb begin
    for (int h = 0; h < `SOC_NR_HOSTS; h++) begin
      gnt_vec[h] = host_gnt_i[h];
    end
  end

  // At most one host wins per cycle
  assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni) $onehot0(gnt_vec))
    else begin
      fail_cnt++;
      $error("More than one host granted in the same cycle");
    end

  for (genvar h = 0; h < `SOC_NR_HOSTS; h++) begin : g_host
    assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                     host_gnt_i[h] |=> host_rvalid_i[h])
      else begin
        fail_cnt++;
        $error("Host %0d got no response one cycle after its grant", h);
      end

    // No response without a grant one cycle before
    assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                     host_rvalid_i[h] |-> $past(host_gnt_i[h]))
      else begin
        fail_cnt++;
        $error("Host %0d got a response without a grant one cycle before", h);
      end

    assert property (@(posedge clk_sys_i) disable iff (!rst_sys_ni)
                     host_err_i[h] |-> host_rvalid_i[h])
      else begin
        fail_cnt++;
        $error("Host %0d saw err without rvalid", h);
      end
  end

endmodule

bind soc_bus_arbiter soc_bus_asserts i_bus_asserts (
  .clk_sys_i     (clk_sys_i),
  .rst_sys_ni    (rst_sys_ni),
  .host_gnt_i    (host_gnt_o),
  .host_rvalid_i (host_rvalid_o),
  .host_err_i    (host_err_o)
);

// File: soc_top.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_top (
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,

  input  logic                     host_req_i    [`SOC_NR_HOSTS],
  input  soc_bus_pkg::soc_addr_u   host_addr_i   [`SOC_NR_HOSTS],
  input  logic                     host_we_i     [`SOC_NR_HOSTS],
  input  logic [`SOC_DATA_W/8-1:0] host_be_i     [`SOC_NR_HOSTS],
  input  logic [`SOC_DATA_W-1:0]   host_wdata_i  [`SOC_NR_HOSTS],
  output logic                     host_gnt_o    [`SOC_NR_HOSTS],
  output logic                     host_rvalid_o [`SOC_NR_HOSTS],
  output logic [`SOC_DATA_W-1:0]   host_rdata_o  [`SOC_NR_HOSTS],
  output logic                     host_err_o    [`SOC_NR_HOSTS],

  input  logic [`SOC_GPI_W-1:0]    gp_i,
  output logic [`SOC_GPO_W-1:0]    gp_o,
  output logic                     timer_irq_o
);
  import soc_bus_pkg::*;

  // Shared request fields, only dev_req is per device
  logic [nr_devices-1:0]    dev_req;
  soc_addr_u                dev_addr;
  logic                     dev_we;
  logic [`SOC_DATA_W/8-1:0] dev_be;
  logic [`SOC_DATA_W-1:0]   dev_wdata;

  logic                     ram_rvalid, gpio_rvalid, timer_rvalid;
  logic [`SOC_DATA_W-1:0]   ram_rdata, gpio_rdata, timer_rdata;

  soc_bus_arbiter i_arbiter (
    .clk_sys_i,
    .rst_sys_ni,
    .host_req_i,
    .host_addr_i,
    .host_we_i,
    .host_be_i,
    .host_wdata_i,
    .host_gnt_o,
    .host_rvalid_o,
    .host_rdata_o,
    .host_err_o,
    .dev_req_o      (dev_req),
    .dev_addr_o     (dev_addr),
    .dev_we_o       (dev_we),
    .dev_be_o       (dev_be),
    .dev_wdata_o    (dev_wdata),
    .ram_rvalid_i   (ram_rvalid),
    .ram_rdata_i    (ram_rdata),
    .gpio_rvalid_i  (gpio_rvalid),
    .gpio_rdata_i   (gpio_rdata),
    .timer_rvalid_i (timer_rvalid),
    .timer_rdata_i  (timer_rdata)
  );

  soc_ram i_ram (
    .clk_sys_i,
    .rst_sys_ni,
    .req_i    (dev_req[dev_ram]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (ram_rvalid),
    .rdata_o  (ram_rdata)
  );

  soc_gpio i_gpio (
    .clk_sys_i,
    .rst_sys_ni,
    .req_i    (dev_req[dev_gpio]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .gp_i,
    .rvalid_o (gpio_rvalid),
    .rdata_o  (gpio_rdata),
    .gp_o
  );

  soc_timer i_timer (
    .clk_sys_i,
    .rst_sys_ni,
    .req_i    (dev_req[dev_timer]),
    .we_i     (dev_we),
    .be_i     (dev_be),
    .addr_i   (dev_addr),
    .wdata_i  (dev_wdata),
    .rvalid_o (timer_rvalid),
    .rdata_o  (timer_rdata),
    .timer_irq_o
  );

endmodule

// File: soc_timer.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_timer (
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`SOC_DATA_W/8-1:0] be_i,
  input  soc_bus_pkg::soc_addr_u   addr_i,
  input  logic [`SOC_DATA_W-1:0]   wdata_i,
  output logic                     rvalid_o,
  output logic [`SOC_DATA_W-1:0]   rdata_o,
  output logic                     timer_irq_o
);
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  timer_reg_e  reg_sel;
  logic [63:0] mtime_q, mtime_d;
  logic [63:0] mtimecmp_q, mtimecmp_d;

  // Byte-wise update of one 32-bit half
  function automatic logic [31:0] be_merge(logic [31:0] old_w, logic [31:0] new_w,
                                           logic [3:0] be);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  assign reg_sel = timer_reg_e'(addr_i.periph.reg_idx[$bits(timer_reg_e)-1:0]);

  always_comb begin
    mtime_d    = mtime_q + 64'd1;  // Free running, one tick per cycle
    mtimecmp_d = mtimecmp_q;
    if (req_i && we_i) begin
      case (reg_sel)
        mtime_lo:    mtime_d[31:0]     = be_merge(mtime_q[31:0], wdata_i, be_i);
        mtime_hi:    mtime_d[63:32]    = be_merge(mtime_q[63:32], wdata_i, be_i);
        mtimecmp_lo: mtimecmp_d[31:0]  = be_merge(mtimecmp_q[31:0], wdata_i, be_i);
        default:     mtimecmp_d[63:32] = be_merge(mtimecmp_q[63:32], wdata_i, be_i);
      endcase
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;  // Far future, no interrupt
      timer_irq_o <= 1'b0;
      rvalid_o    <= 1'b0;
    end else begin
      mtime_q     <= mtime_d;
      mtimecmp_q  <= mtimecmp_d;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      rvalid_o    <= req_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      case (reg_sel)
        mtime_lo:    rdata_o <= mtime_q[31:0];
        mtime_hi:    rdata_o <= mtime_q[63:32];
        mtimecmp_lo: rdata_o <= mtimecmp_q[31:0];
        default:     rdata_o <= mtimecmp_q[63:32];
      endcase
    end
  end

endmodule

// File: soc_gpio.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_gpio (
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`SOC_DATA_W/8-1:0] be_i,
  input  soc_bus_pkg::soc_addr_u   addr_i,
  input  logic [`SOC_DATA_W-1:0]   wdata_i,
  input  logic [`SOC_GPI_W-1:0]    gp_i,
  output logic                     rvalid_o,
  output logic [`SOC_DATA_W-1:0]   rdata_o,
  output logic [`SOC_GPO_W-1:0]    gp_o
);
  import soc_bus_pkg::*;
  import soc_periph_pkg::*;

  localparam int unsigned data_w = `SOC_DATA_W;

  gpio_reg_e              reg_sel;
  logic [`SOC_GPI_W-1:0]  gp_meta_q;  // First synchronizer stage
  logic [`SOC_GPI_W-1:0]  gp_in_q;

  assign reg_sel = gpio_reg_e'(addr_i.periph.reg_idx[$bits(gpio_reg_e)-1:0]);

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      gp_meta_q <= '0;
      gp_in_q   <= '0;
      gp_o      <= '0;
      rvalid_o  <= 1'b0;
    end else begin
      gp_meta_q <= gp_i;
      gp_in_q   <= gp_meta_q;
      rvalid_o  <= req_i;
      if (req_i && we_i && reg_sel == gpio_out) begin  // gpio_in is read only
        for (int b = 0; b < `SOC_GPO_W / 8; b++) begin
          if (be_i[b]) gp_o[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      rdata_o <= (reg_sel == gpio_out) ? data_w'(gp_o) : data_w'(gp_in_q);
    end
  end

endmodule

// File: soc_ram.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_ram (
  input  logic                     clk_sys_i,
  input  logic                     rst_sys_ni,
  input  logic                     req_i,
  input  logic                     we_i,
  input  logic [`SOC_DATA_W/8-1:0] be_i,
  input  soc_bus_pkg::soc_addr_u   addr_i,
  input  logic [`SOC_DATA_W-1:0]   wdata_i,
  output logic                     rvalid_o,
  output logic [`SOC_DATA_W-1:0]   rdata_o
);
  import soc_bus_pkg::*;

  localparam int unsigned depth = `SOC_RAM_SIZE / (`SOC_DATA_W / 8);

  logic [`SOC_DATA_W-1:0] mem [depth];

  always_ff @(posedge clk_sys_i) begin
    if (req_i) begin
      if (we_i) begin
        for (int b = 0; b < `SOC_DATA_W / 8; b++) begin
          if (be_i[b]) mem[addr_i.ram.word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      rdata_o <= mem[addr_i.ram.word_idx];  // Old word on a write
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= req_i;
    end
  end

endmodule

// File: soc_bus_arbiter.sv
`timescale 1ns/1ps
`include "soc_settings.svh"

module soc_bus_arbiter (
  input  logic                          clk_sys_i,
  input  logic                          rst_sys_ni,

  input  logic                          host_req_i    [`SOC_NR_HOSTS],
  input  soc_bus_pkg::soc_addr_u        host_addr_i   [`SOC_NR_HOSTS],
  input  logic                          host_we_i     [`SOC_NR_HOSTS],
  input  logic [`SOC_DATA_W/8-1:0]      host_be_i     [`SOC_NR_HOSTS],
  input  logic [`SOC_DATA_W-1:0]        host_wdata_i  [`SOC_NR_HOSTS],
  output logic                          host_gnt_o    [`SOC_NR_HOSTS],
  output logic                          host_rvalid_o [`SOC_NR_HOSTS],
  output logic [`SOC_DATA_W-1:0]        host_rdata_o  [`SOC_NR_HOSTS],
  output logic                          host_err_o    [`SOC_NR_HOSTS],

  output logic [soc_bus_pkg::nr_devices-1:0] dev_req_o,
  output soc_bus_pkg::soc_addr_u        dev_addr_o,
  output logic                          dev_we_o,
  output logic [`SOC_DATA_W/8-1:0]      dev_be_o,
  output logic [`SOC_DATA_W-1:0]        dev_wdata_o,

  input  logic                          ram_rvalid_i,
  input  logic [`SOC_DATA_W-1:0]        ram_rdata_i,
  input  logic                          gpio_rvalid_i,
  input  logic [`SOC_DATA_W-1:0]        gpio_rdata_i,
  input  logic                          timer_rvalid_i,
  input  logic [`SOC_DATA_W-1:0]        timer_rdata_i
);
  import soc_bus_pkg::*;

  localparam soc_addr_u ram_base   = `SOC_RAM_START;
  localparam soc_addr_u gpio_base  = `SOC_GPIO_START;
  localparam soc_addr_u timer_base = `SOC_TIMER_START;

  logic                   win_valid;
  bus_host_e              win_host;
  soc_addr_u              win_addr;
  bus_device_e            win_dev;

  logic                   rsp_pend_q;  // A grant was given last cycle
  bus_host_e              rsp_host_q;
  bus_device_e            rsp_dev_q;
  logic                   rsp_ok;
  logic                   rsp_err;
  logic [`SOC_DATA_W-1:0] rsp_rdata;
  logic                   rsp_fire;

  // Fixed priority, lowest index wins
  always_comb begin
    win_valid = 1'b0;
    win_host  = core_data;
    for (int h = `SOC_NR_HOSTS - 1; h >= 0; h--) begin
      if (host_req_i[h]) begin
        win_valid = 1'b1;
        win_host  = bus_host_e'(h);
      end
    end
  end

  assign win_addr = host_addr_i[win_host];

  always_comb begin
    if (win_addr.ram.region == ram_base.ram.region) begin
      win_dev = dev_ram;
    end else if (win_addr.periph.page == gpio_base.periph.page) begin
      win_dev = dev_gpio;
    end else if (win_addr.periph.page == timer_base.periph.page) begin
      win_dev = dev_timer;
    end else begin
      win_dev = dev_none;
    end
  end

  always_comb begin
    dev_req_o = '0;
    if (win_valid && win_dev != dev_none) begin
      dev_req_o[win_dev] = 1'b1;  // Unmapped accesses reach no device
    end
    for (int h = 0; h < `SOC_NR_HOSTS; h++) begin
      host_gnt_o[h] = win_valid && (win_host == bus_host_e'(h));
    end
  end

  assign dev_addr_o  = win_addr;
  assign dev_we_o    = host_we_i[win_host];
  assign dev_be_o    = host_be_i[win_host];
  assign dev_wdata_o = host_wdata_i[win_host];

  always_ff @(posedge clk_sys_i or negedge rst_sys_ni) begin
    if (!rst_sys_ni) begin
      rsp_pend_q <= 1'b0;
      rsp_host_q <= core_data;
      rsp_dev_q  <= dev_none;
    end else begin
      rsp_pend_q <= win_valid;
      if (win_valid) begin
        rsp_host_q <= win_host;
        rsp_dev_q  <= win_dev;
      end
    end
  end

  // Pick the answering device
  always_comb begin
    rsp_ok    = 1'b1;
    rsp_err   = 1'b0;
    rsp_rdata = '0;
    case (rsp_dev_q)
      dev_ram: begin
        rsp_ok    = ram_rvalid_i;
        rsp_rdata = ram_rdata_i;
      end
      dev_gpio: begin
        rsp_ok    = gpio_rvalid_i;
        rsp_rdata = gpio_rdata_i;
      end
      dev_timer: begin
        rsp_ok    = timer_rvalid_i;
        rsp_rdata = timer_rdata_i;
      end
      default: rsp_err = 1'b1;  // Error reply, rdata stays zero
    endcase
  end

  assign rsp_fire = rsp_pend_q & rsp_ok;

  always_comb begin
    for (int h = 0; h < `SOC_NR_HOSTS; h++) begin
      host_rvalid_o[h] = rsp_fire && (rsp_host_q == bus_host_e'(h));
      host_err_o[h]    = rsp_fire && rsp_err && (rsp_host_q == bus_host_e'(h));
      host_rdata_o[h]  = rsp_rdata;
    end
  end

endmodule

// File: soc_periph_pkg.sv
package soc_periph_pkg;

  // GPIO register map, word offsets within the page
  typedef enum logic {
    gpio_out = 1'b0,
    gpio_in  = 1'b1
  } gpio_reg_e;

  // Timer register map, 32-bit halves of the two 64-bit registers
  typedef enum logic [1:0] {
    mtime_lo,
    mtime_hi,
    mtimecmp_lo,
    mtimecmp_hi
  } timer_reg_e;

endpackage

// File: soc_bus_pkg.sv
`include "soc_settings.svh"

package soc_bus_pkg;

  // Field widths of the two address views
  localparam int unsigned ram_idx_w     = $clog2(`SOC_RAM_SIZE) - 2;
  localparam int unsigned ram_region_w  = `SOC_DATA_W - ram_idx_w - 2;
  localparam int unsigned periph_idx_w  = $clog2(`SOC_PERIPH_SIZE) - 2;
  localparam int unsigned periph_page_w = `SOC_DATA_W - periph_idx_w - 2;

  typedef enum int {
    core_data = 0,
    dbg_host  = 1
  } bus_host_e;

  typedef enum logic [1:0] {
    dev_ram,
    dev_gpio,
    dev_timer,
    dev_none    // No window hit, answered with an error
  } bus_device_e;

  localparam int unsigned nr_devices = dev_none;

  typedef struct packed {
    logic [ram_region_w-1:0] region;
    logic [ram_idx_w-1:0]    word_idx;
    logic [1:0]              byte_off;
  } ram_addr_t;

  typedef struct packed {
    logic [periph_page_w-1:0] page;
    logic [periph_idx_w-1:0]  reg_idx;
    logic [1:0]               byte_off;
  } periph_addr_t;

  // Same bus address word, seen by RAM or by a register block
  typedef union packed {
    ram_addr_t    ram;
    periph_addr_t periph;
  } soc_addr_u;

endpackage

// File: soc_settings.svh
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus geometry
`define SOC_DATA_W   32    // Data and address width
`define SOC_NR_HOSTS 2     // core_data and dbg_host

// RAM window, kept small for simulation
`define SOC_RAM_START 32'h0010_0000
`define SOC_RAM_SIZE  (16 * 1024)

// Peripheral windows share one page size
`define SOC_GPIO_START  32'h8000_0000
`define SOC_TIMER_START 32'h8000_2000
`define SOC_PERIPH_SIZE (4 * 1024)

// GPIO pin counts
`define SOC_GPI_W 8
`define SOC_GPO_W 16

`endif
